// File: source/axi_pkg.sv
// ***********************************************************
// AXI4 field widths and encodings for the SRAM slave.
// Only FIXED and INCR bursts are served. WRAP has a name
// here only so that it can be rejected.
// The slave never answers with anything but OKAY.
// ***********************************************************

package axi_pkg;

	// Bus field widths
	localparam int axi_id_width = 4;
	localparam int axi_addr_width = 16;
	localparam int axi_len_width = 8;
	localparam int axi_size_width = 3;

	// AxBURST encoding
	typedef enum logic [1:0]
	{
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} axi_burst_t;

	// xRESP encoding, the only code this slave returns
	localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage

// File: source/sram_pkg.sv
// ***********************************************************
// Geometry of the banked SRAM and the controller states.
// A memory address is {cell, index, byte offset}, so the
// cell count and depth must stay powers of two.
// ***********************************************************

package sram_pkg;

	localparam int data_width = 32;
	localparam int num_byte = 4;
	localparam int byte_offset_width = 2;

	localparam int num_cell = 4;
	localparam int cell_depth = 64;
	localparam int cell_index_width = 6;
	localparam int cell_select_width = 2;

	localparam int mem_addr_width = cell_select_width + cell_index_width + byte_offset_width;

	// Bus address of byte 0 of the memory
	localparam logic [15:0] base_addr = 16'h1000;

	typedef enum logic [2:0]
	{
		st_idle,
		st_read,
		st_load_write,
		st_write,
		st_resp
	} ctrl_state_t;

endpackage

// File: source/aw_buffer.sv
// ***********************************************************
// One-entry write address buffer.
// A single register slot, so a pop and a push never fall in
// the same cycle and back-to-back entries see one bubble.
// ***********************************************************

`timescale 1ns/1ns

module aw_buffer
	import axi_pkg::*;
(
	input  logic clk,
	input  logic rstnn,
	input  logic [axi_id_width-1:0] in_id,
	input  logic [axi_addr_width-1:0] in_addr,
	input  logic [axi_len_width-1:0] in_len,
	input  logic [axi_size_width-1:0] in_size,
	input  logic [1:0] in_burst,
	input  logic in_valid,
	output logic in_ready,
	output logic [axi_id_width-1:0] out_id,
	output logic [axi_addr_width-1:0] out_addr,
	output logic [axi_len_width-1:0] out_len,
	output logic [axi_size_width-1:0] out_size,
	output axi_burst_t out_burst,
	output logic out_valid,
	input  logic pop
);

	logic full;
	logic push;

	assign in_ready = !full;
	assign push = in_valid && in_ready;
	assign out_valid = full;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			full <= 1'b0;
		else if (push)
			full <= 1'b1;
		else if (pop)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			out_id <= in_id;
			out_addr <= in_addr;
			out_len <= in_len;
			out_size <= in_size;
			out_burst <= axi_burst_t'(in_burst);
		end
	end

	a_pop_when_full: assert property (@(posedge clk) disable iff (!rstnn) pop |-> full)
		else $error("aw_buffer popped while empty");

endmodule

// File: source/burst_addr_gen.sv
// ***********************************************************
// Burst address generator for one burst at a time.
// Addresses are memory-relative. INCR beats after the first
// are aligned to the transfer size, FIXED holds the address.
// WRAP is not supported and must never be loaded.
// ***********************************************************

`timescale 1ns/1ns

module burst_addr_gen
	import axi_pkg::*;
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rstnn,
	input  logic load,
	input  logic step,
	input  logic [mem_addr_width-1:0] start_addr,
	input  logic [axi_len_width-1:0] len,
	input  logic [axi_size_width-1:0] size,
	input  axi_burst_t burst,
	output logic [mem_addr_width-1:0] addr,
	output logic active,
	output logic last
);

	logic [axi_len_width-1:0] remain;
	logic [mem_addr_width-1:0] step_size;
	logic is_fixed;
	logic [mem_addr_width-1:0] next_addr;

	assign last = active && (remain == '0);

	// Round down to the transfer size, then move one transfer on
	assign next_addr = (addr & ~(step_size - 1'b1)) + step_size;

	// ***********************************************************
	// Beat count
	// ***********************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			active <= 1'b0;
			remain <= '0;
		end
		else if (load)
		begin
			active <= 1'b1;
			remain <= len;
		end
		else if (step)
		begin
			if (remain == '0)
				active <= 1'b0;
			else
				remain <= remain - 1'b1;
		end
	end

	// ***********************************************************
	// Address
	// ***********************************************************

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			addr <= start_addr;
			step_size <= mem_addr_width'(1) << size;
			is_fixed <= (burst == burst_fixed);
		end
		else if (step && !is_fixed)
			addr <= next_addr;
	end

	a_step_active: assert property (@(posedge clk) disable iff (!rstnn) step |-> active)
		else $error("burst_addr_gen stepped with no burst loaded");

	a_no_wrap: assert property (@(posedge clk) disable iff (!rstnn)
		load |-> (burst != burst_wrap))
		else $error("burst_addr_gen loaded a WRAP burst");

endmodule

// File: source/sram_cell.sv
// ***********************************************************
// Behavioural single-port SRAM cell.
// Bit-granular write enables, one cycle read latency.
// A write cycle leaves rdata as it was. No reset, so
// contents start undefined.
// ***********************************************************

`timescale 1ns/1ns

module sram_cell
	import sram_pkg::*;
(
	input  logic clk,
	input  logic enable,
	input  logic write_enable,
	input  logic [cell_index_width-1:0] index,
	input  logic [data_width-1:0] write_enable_bit,
	input  logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [cell_depth];

	always_ff @(posedge clk)
	begin
		if (enable)
		begin
			// Only the enabled bits take the new value
			if (write_enable)
				mem[index] <= (mem[index] & ~write_enable_bit) | (wdata & write_enable_bit);
			else
				rdata <= mem[index];
		end
	end

endmodule

// File: source/sram_axi_ctrl.sv
// ***********************************************************
// AXI4 to banked SRAM controller.
// One transaction at a time; a waiting read wins over a
// buffered write. Responses are always OKAY.
// Read data comes one cycle after the cell read and is held
// in a register while the master stalls.
// ***********************************************************

`timescale 1ns/1ns

module sram_axi_ctrl
	import axi_pkg::*;
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rstnn,
	input  logic [axi_id_width-1:0] arid,
	input  logic [axi_addr_width-1:0] araddr,
	input  logic [axi_len_width-1:0] arlen,
	input  logic [axi_size_width-1:0] arsize,
	input  logic [1:0] arburst,
	input  logic arvalid,
	output logic arready,
	input  logic [data_width-1:0] wdata,
	input  logic [num_byte-1:0] wstrb,
	input  logic wlast,
	input  logic wvalid,
	output logic wready,
	output logic [axi_id_width-1:0] rid,
	output logic [data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input  logic rready,
	output logic [axi_id_width-1:0] bid,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [axi_id_width-1:0] buf_id,
	input  logic [axi_addr_width-1:0] buf_addr,
	input  logic [axi_len_width-1:0] buf_len,
	input  logic [axi_size_width-1:0] buf_size,
	input  axi_burst_t buf_burst,
	input  logic buf_valid,
	output logic buf_pop,
	output logic [num_cell-1:0] cell_enable_list,
	output logic [num_cell-1:0] cell_write_enable_list,
	output logic [num_cell*cell_index_width-1:0] cell_index_list,
	output logic [num_cell*data_width-1:0] cell_write_enable_bit_list,
	output logic [num_cell*data_width-1:0] cell_wdata_list,
	input  logic [num_cell*data_width-1:0] cell_rdata_list
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic [axi_id_width-1:0] txn_id;

	logic ar_take;
	logic w_fire;
	logic r_fire;
	logic b_fire;
	logic rd_stall;
	logic rd_issue;
	logic wr_issue;

	logic gen_load;
	logic gen_step;
	logic [axi_addr_width-1:0] gen_bus_addr;
	logic [axi_addr_width-1:0] rel_addr;
	logic [axi_len_width-1:0] gen_len;
	logic [axi_size_width-1:0] gen_size;
	axi_burst_t gen_burst;
	logic [mem_addr_width-1:0] gen_addr;
	logic gen_active;
	logic gen_last;

	logic [cell_select_width-1:0] cur_cell;
	logic [cell_index_width-1:0] cur_index;
	logic [data_width-1:0] wbit_enable;

	logic [num_cell-1:0] rd_sel;
	logic [data_width-1:0] rd_live;
	logic hold_valid;
	logic [data_width-1:0] hold_data;

	assign arready = (state == st_idle);
	assign wready = (state == st_write);
	assign bvalid = (state == st_resp);
	assign buf_pop = (state == st_load_write);

	assign ar_take = arvalid && arready;
	assign w_fire = wvalid && wready;
	assign r_fire = rvalid && rready;
	assign b_fire = bvalid && bready;

	assign rd_stall = rvalid && !rready;
	assign rd_issue = (state == st_read) && gen_active && !rd_stall;
	assign wr_issue = w_fire;

	// ***********************************************************
	// State machine
	// ***********************************************************

	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
				if (arvalid)
					state_next = st_read;
				else if (buf_valid)
					state_next = st_load_write;
			st_read:
				if (r_fire && rlast)
					state_next = st_idle;
			st_load_write:
				state_next = st_write;
			st_write:
				if (w_fire && wlast)
					state_next = st_resp;
			st_resp:
				if (b_fire)
					state_next = st_idle;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk)
	begin
		if (ar_take)
			txn_id <= arid;
		else if (state == st_load_write)
			txn_id <= buf_id;
	end

	assign rid = txn_id;
	assign bid = txn_id;
	assign rresp = axi_resp_okay;
	assign bresp = axi_resp_okay;

	// ***********************************************************
	// Burst address generator shared by reads and writes
	// ***********************************************************

	assign gen_load = ar_take || (state == st_load_write);
	assign gen_step = rd_issue || wr_issue;
	assign gen_bus_addr = (state == st_load_write) ? buf_addr : araddr;
	assign gen_len = (state == st_load_write) ? buf_len : arlen;
	assign gen_size = (state == st_load_write) ? buf_size : arsize;
	assign gen_burst = (state == st_load_write) ? buf_burst : axi_burst_t'(arburst);
	assign rel_addr = gen_bus_addr - base_addr;

	burst_addr_gen i_burst_addr_gen
	(
		.clk(clk),
		.rstnn(rstnn),
		.load(gen_load),
		.step(gen_step),
		.start_addr(rel_addr[mem_addr_width-1:0]),
		.len(gen_len),
		.size(gen_size),
		.burst(gen_burst),
		.addr(gen_addr),
		.active(gen_active),
		.last(gen_last)
	);

	// Byte offset is unused since wstrb already picks the lanes
	assign {cur_cell, cur_index} = gen_addr[mem_addr_width-1:byte_offset_width];

	always_comb
	begin
		for (int b = 0; b < num_byte; b++)
			wbit_enable[b*8 +: 8] = {8{wstrb[b]}};
	end

	// ***********************************************************
	// Cell strobes
	// ***********************************************************

	for (genvar k = 0; k < num_cell; k++)
	begin : g_cell_port
		logic hit;

		assign hit = (cur_cell == cell_select_width'(k));
		assign cell_enable_list[k] = hit && (rd_issue || wr_issue);
		assign cell_write_enable_list[k] = hit && wr_issue;
		assign cell_index_list[k*cell_index_width +: cell_index_width] = cur_index;
		assign cell_write_enable_bit_list[k*data_width +: data_width] =
			(hit && wr_issue) ? wbit_enable : '0;
		assign cell_wdata_list[k*data_width +: data_width] = wdata;
	end

	// ***********************************************************
	// Read return path
	// ***********************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			rvalid <= 1'b0;
			rlast <= 1'b0;
		end
		else if ((state == st_read) && !rd_stall)
		begin
			rvalid <= gen_active;
			rlast <= gen_last;
		end
	end

	// The generator has moved on by the time data returns,
	// so remember which cell was read
	always_ff @(posedge clk)
	begin
		if (rd_issue)
			rd_sel <= cell_enable_list;
	end

	always_comb
	begin
		rd_live = '0;
		for (int k = 0; k < num_cell; k++)
		begin
			if (rd_sel[k])
				rd_live = rd_live | cell_rdata_list[k*data_width +: data_width];
		end
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			hold_valid <= 1'b0;
		else
			hold_valid <= rd_stall;
	end

	// Capture once on the first stalled cycle
	always_ff @(posedge clk)
	begin
		if (rd_stall && !hold_valid)
			hold_data <= rd_live;
	end

	assign rdata = hold_valid ? hold_data : rd_live;

	a_wlast_len: assert property (@(posedge clk) disable iff (!rstnn)
		w_fire |-> (wlast == gen_last))
		else $error("wlast disagrees with the burst length");

	a_r_stable: assert property (@(posedge clk) disable iff (!rstnn)
		rd_stall |=> rvalid && $stable(rdata) && $stable(rlast))
		else $error("read beat changed under back-pressure");

	a_no_access_in_stall: assert property (@(posedge clk) disable iff (!rstnn)
		rd_stall |-> (cell_enable_list == '0))
		else $error("cell accessed while a read beat waits");

endmodule

// File: source/sram_axi_subsystem.sv
// ***********************************************************
// AXI4 slave with banked on-chip SRAM.
// Memory starts at base_addr; addresses outside it alias
// into the banks. FIXED and INCR bursts only.
// ***********************************************************

`timescale 1ns/1ns

module sram_axi_subsystem
	import axi_pkg::*;
	import sram_pkg::*;
(
	input  logic clk,
	input  logic rstnn,
	input  logic [axi_id_width-1:0] awid,
	input  logic [axi_addr_width-1:0] awaddr,
	input  logic [axi_len_width-1:0] awlen,
	input  logic [axi_size_width-1:0] awsize,
	input  logic [1:0] awburst,
	input  logic awvalid,
	output logic awready,
	input  logic [data_width-1:0] wdata,
	input  logic [num_byte-1:0] wstrb,
	input  logic wlast,
	input  logic wvalid,
	output logic wready,
	output logic [axi_id_width-1:0] bid,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [axi_id_width-1:0] arid,
	input  logic [axi_addr_width-1:0] araddr,
	input  logic [axi_len_width-1:0] arlen,
	input  logic [axi_size_width-1:0] arsize,
	input  logic [1:0] arburst,
	input  logic arvalid,
	output logic arready,
	output logic [axi_id_width-1:0] rid,
	output logic [data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input  logic rready
);

	logic [axi_id_width-1:0] buf_id;
	logic [axi_addr_width-1:0] buf_addr;
	logic [axi_len_width-1:0] buf_len;
	logic [axi_size_width-1:0] buf_size;
	axi_burst_t buf_burst;
	logic buf_valid;
	logic buf_pop;

	logic [num_cell-1:0] cell_enable_list;
	logic [num_cell-1:0] cell_write_enable_list;
	logic [num_cell*cell_index_width-1:0] cell_index_list;
	logic [num_cell*data_width-1:0] cell_write_enable_bit_list;
	logic [num_cell*data_width-1:0] cell_wdata_list;
	logic [num_cell*data_width-1:0] cell_rdata_list;

	aw_buffer i_aw_buffer
	(
		.clk(clk),
		.rstnn(rstnn),
		.in_id(awid),
		.in_addr(awaddr),
		.in_len(awlen),
		.in_size(awsize),
		.in_burst(awburst),
		.in_valid(awvalid),
		.in_ready(awready),
		.out_id(buf_id),
		.out_addr(buf_addr),
		.out_len(buf_len),
		.out_size(buf_size),
		.out_burst(buf_burst),
		.out_valid(buf_valid),
		.pop(buf_pop)
	);

	sram_axi_ctrl i_sram_axi_ctrl
	(
		.clk(clk),
		.rstnn(rstnn),
		.arid(arid),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.rid(rid),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.bid(bid),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.buf_id(buf_id),
		.buf_addr(buf_addr),
		.buf_len(buf_len),
		.buf_size(buf_size),
		.buf_burst(buf_burst),
		.buf_valid(buf_valid),
		.buf_pop(buf_pop),
		.cell_enable_list(cell_enable_list),
		.cell_write_enable_list(cell_write_enable_list),
		.cell_index_list(cell_index_list),
		.cell_write_enable_bit_list(cell_write_enable_bit_list),
		.cell_wdata_list(cell_wdata_list),
		.cell_rdata_list(cell_rdata_list)
	);

	// One cell per bank
	for (genvar k = 0; k < num_cell; k++)
	begin : g_bank
		sram_cell i_sram_cell
		(
			.clk(clk),
			.enable(cell_enable_list[k]),
			.write_enable(cell_write_enable_list[k]),
			.index(cell_index_list[k*cell_index_width +: cell_index_width]),
			.write_enable_bit(cell_write_enable_bit_list[k*data_width +: data_width]),
			.wdata(cell_wdata_list[k*data_width +: data_width]),
			.rdata(cell_rdata_list[k*data_width +: data_width])
		);
	end

endmodule

// File: verification/tb_sram_axi_subsystem.sv
// ***********************************************************
// Testbench for the AXI4 SRAM slave.
// One transaction at a time per channel, driven on the
// falling edge. A byte shadow indexed by bus address predicts
// every read beat, so only written bytes may be read back.
// Addresses stay inside 16'h1000 to 16'h13ff.
// ***********************************************************

`timescale 1ns/1ns

module tb_sram_axi_subsystem
	import axi_pkg::*;
	import sram_pkg::*;
;

	// Summed beats over all tests bound the run
	localparam int total_beats = 98;
	localparam int cycle_limit = 3 * total_beats + 400;

	logic clk;
	logic rstnn;
	logic [axi_id_width-1:0] awid;
	logic [axi_addr_width-1:0] awaddr;
	logic [axi_len_width-1:0] awlen;
	logic [axi_size_width-1:0] awsize;
	logic [1:0] awburst;
	logic awvalid;
	logic awready;
	logic [data_width-1:0] wdata;
	logic [num_byte-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [axi_id_width-1:0] bid;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axi_id_width-1:0] arid;
	logic [axi_addr_width-1:0] araddr;
	logic [axi_len_width-1:0] arlen;
	logic [axi_size_width-1:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	logic [axi_id_width-1:0] rid;
	logic [data_width-1:0] rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	logic [7:0] shadow [0:65535];
	logic [data_width-1:0] exp_word [0:255];
	logic [axi_len_width-1:0] exp_rlen;
	logic [axi_id_width-1:0] exp_arid;
	logic [axi_id_width-1:0] exp_awid;
	logic [8:0] r_beat;
	logic [31:0] lfsr = 32'hbefce021;
	int error_count = 0;
	int errors_before = 0;
	int test_count = 0;
	int cycle_count;

	sram_axi_subsystem i_sram_axi_subsystem (.*);

	always #20 clk = ~clk;

	// ***********************************************************
	// Helpers
	// ***********************************************************

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		take_bits = v;
	endfunction

	// INCR aligns to the size and moves on while FIXED stays
	function automatic logic [15:0] next_beat_addr(input logic [15:0] a,
		input logic [2:0] size, input axi_burst_t burst);
		logic [15:0] nbytes;
		nbytes = 16'd1 << size;
		if (burst == burst_fixed)
			next_beat_addr = a;
		else
			next_beat_addr = (a & ~(nbytes - 16'd1)) + nbytes;
	endfunction

	// Byte lanes that a transfer of this size at this address uses
	function automatic logic [3:0] lane_mask(input logic [15:0] a, input logic [2:0] size);
		int nbytes;
		int first;
		nbytes = 1 << size;
		first = int'(a[1:0]) & ~(nbytes - 1);
		lane_mask = 4'(((1 << nbytes) - 1) << first);
	endfunction

	function automatic logic [31:0] shadow_word(input logic [15:0] a);
		shadow_word = {shadow[{a[15:2], 2'd3}], shadow[{a[15:2], 2'd2}],
			shadow[{a[15:2], 2'd1}], shadow[{a[15:2], 2'd0}]};
	endfunction

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		error_count++;
		$display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count == errors_before)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d failed checks", test_count, name,
				error_count - errors_before);
		errors_before = error_count;
	endtask

	// ***********************************************************
	// AXI master tasks entered and left on a falling edge
	// ***********************************************************

	task automatic send_aw(input logic [3:0] id, input logic [15:0] addr,
		input logic [7:0] len, input logic [2:0] size, input axi_burst_t burst);
		logic fire;
		exp_awid = id;
		awid = id;
		awaddr = addr;
		awlen = len;
		awsize = size;
		awburst = burst;
		awvalid = 1'b1;
		fire = 1'b0;
		while (!fire)
		begin
			fire = awready;
			@(negedge clk);
		end
		awvalid = 1'b0;
	endtask

	task automatic send_w(input logic [15:0] addr, input logic [7:0] len,
		input logic [2:0] size, input axi_burst_t burst, input logic rand_strb);
		logic [15:0] a;
		logic fire;
		a = addr;
		for (int beat = 0; beat <= int'(len); beat++)
		begin
			wvalid = 1'b1;
			wdata = take_bits(32);
			wstrb = lane_mask(a, size);
			if (rand_strb)
				wstrb = wstrb & 4'(take_bits(4));
			wlast = (beat == int'(len));
			fire = 1'b0;
			while (!fire)
			begin
				fire = wready;
				@(negedge clk);
			end
			// Shadow follows the accepted beat
			for (int b = 0; b < num_byte; b++)
				if (wstrb[b])
					shadow[{a[15:2], 2'(b)}] = wdata[b*8 +: 8];
			a = next_beat_addr(a, size, burst);
		end
		wvalid = 1'b0;
		wlast = 1'b0;
	endtask

	task automatic wait_b(input logic gappy);
		logic fire;
		fire = 1'b0;
		while (!fire)
		begin
			bready = gappy ? (take_bits(2) != 0) : 1'b1;
			fire = bvalid && bready;
			@(negedge clk);
		end
		bready = 1'b0;
	endtask

	task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
		input logic [7:0] len, input logic [2:0] size, input axi_burst_t burst,
		input logic rand_strb, input logic gappy);
		send_aw(id, addr, len, size, burst);
		send_w(addr, len, size, burst, rand_strb);
		wait_b(gappy);
	endtask

	task automatic send_ar(input logic [3:0] id, input logic [15:0] addr,
		input logic [7:0] len, input logic [2:0] size, input axi_burst_t burst);
		logic [15:0] a;
		logic fire;
		a = addr;
		for (int i = 0; i <= int'(len); i++)
		begin
			exp_word[i] = shadow_word(a);
			a = next_beat_addr(a, size, burst);
		end
		exp_arid = id;
		exp_rlen = len;
		r_beat = '0;
		arid = id;
		araddr = addr;
		arlen = len;
		arsize = size;
		arburst = burst;
		arvalid = 1'b1;
		fire = 1'b0;
		while (!fire)
		begin
			fire = arready;
			@(negedge clk);
		end
		arvalid = 1'b0;
	endtask

	task automatic recv_r(input logic gappy);
		logic fire;
		logic seen_last;
		logic done;
		done = 1'b0;
		while (!done)
		begin
			rready = gappy ? (take_bits(2) != 0) : 1'b1;
			fire = rvalid && rready;
			seen_last = rlast;
			@(negedge clk);
			if (fire)
			begin
				r_beat = r_beat + 9'd1;
				done = seen_last;
			end
		end
		rready = 1'b0;
	endtask

	task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
		input logic [7:0] len, input logic [2:0] size, input axi_burst_t burst,
		input logic gappy);
		send_ar(id, addr, len, size, burst);
		recv_r(gappy);
	endtask

	// ***********************************************************
	// Checks
	// ***********************************************************

	a_reset_state: assert property (@(posedge clk) $rose(rstnn) |->
		({rvalid, bvalid, wready, arready, awready} == 5'b00011))
		else flag_mismatch("rvalid,bvalid,wready,arready,awready",
			32'($sampled({rvalid, bvalid, wready, arready, awready})), 32'h3);

	a_rdata: assert property (@(posedge clk) disable iff (!rstnn)
		(rvalid && rready) |-> (rdata == exp_word[r_beat[7:0]]))
		else flag_mismatch("rdata", $sampled(rdata), $sampled(exp_word[r_beat[7:0]]));

	// rlast only on the beat that matches arlen
	a_rlast: assert property (@(posedge clk) disable iff (!rstnn)
		(rvalid && rready) |-> (rlast == (r_beat == {1'b0, exp_rlen})))
		else flag_mismatch("rlast", 32'($sampled(rlast)),
			32'($sampled(r_beat == {1'b0, exp_rlen})));

	a_rid: assert property (@(posedge clk) disable iff (!rstnn)
		rvalid |-> (rid == exp_arid))
		else flag_mismatch("rid", 32'($sampled(rid)), 32'($sampled(exp_arid)));

	// OKAY is 2'b00 on both response channels
	a_rresp: assert property (@(posedge clk) disable iff (!rstnn)
		rvalid |-> (rresp == 2'b00))
		else flag_mismatch("rresp", 32'($sampled(rresp)), 32'h0);

	a_bid: assert property (@(posedge clk) disable iff (!rstnn)
		bvalid |-> (bid == exp_awid))
		else flag_mismatch("bid", 32'($sampled(bid)), 32'($sampled(exp_awid)));

	a_bresp: assert property (@(posedge clk) disable iff (!rstnn)
		bvalid |-> (bresp == 2'b00))
		else flag_mismatch("bresp", 32'($sampled(bresp)), 32'h0);

	// ***********************************************************
	// Run limit and test sequence
	// ***********************************************************

	initial
	begin
		cycle_count = 0;
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", cycle_limit);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rstnn = 1'b0;
		{awid, awaddr, awlen, awsize, awburst, awvalid} = '0;
		{wdata, wstrb, wlast, wvalid, bready} = '0;
		{arid, araddr, arlen, arsize, arburst, arvalid, rready} = '0;
		{exp_rlen, exp_arid, exp_awid, r_beat} = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstnn = 1'b1;
		repeat (2) @(negedge clk);
		report_test("reset_state");

		write_burst(4'h3, 16'h1010, 8'd0, 3'd2, burst_incr, 1'b0, 1'b0);
		read_burst(4'h5, 16'h1010, 8'd0, 3'd2, burst_incr, 1'b0);
		report_test("single_beat");

		// 16 words from 16'h10e0 run into the second cell
		write_burst(4'h7, 16'h10e0, 8'd15, 3'd2, burst_incr, 1'b0, 1'b0);
		read_burst(4'h9, 16'h10e0, 8'd15, 3'd2, burst_incr, 1'b0);
		report_test("incr_burst");

		write_burst(4'h1, 16'h1200, 8'd3, 3'd2, burst_incr, 1'b0, 1'b0);
		write_burst(4'h2, 16'h1201, 8'd3, 3'd0, burst_incr, 1'b0, 1'b0);
		write_burst(4'h4, 16'h1208, 8'd1, 3'd1, burst_incr, 1'b0, 1'b0);
		write_burst(4'h6, 16'h120c, 8'd0, 3'd2, burst_incr, 1'b1, 1'b0);
		read_burst(4'h8, 16'h1200, 8'd3, 3'd2, burst_incr, 1'b0);
		report_test("partial_narrow");

		write_burst(4'ha, 16'h1300, 8'd0, 3'd2, burst_incr, 1'b0, 1'b0);
		write_burst(4'hb, 16'h1300, 8'd3, 3'd2, burst_fixed, 1'b1, 1'b0);
		read_burst(4'hc, 16'h1300, 8'd3, 3'd2, burst_fixed, 1'b0);
		report_test("fixed_burst");

		// Write posted over the words being read, so it must wait
		write_burst(4'hd, 16'h1380, 8'd15, 3'd2, burst_incr, 1'b0, 1'b1);
		send_ar(4'he, 16'h1380, 8'd15, 3'd2, burst_incr);
		send_aw(4'hf, 16'h1380, 8'd3, 3'd2, burst_incr);
		recv_r(1'b1);
		send_w(16'h1380, 8'd3, 3'd2, burst_incr, 1'b0);
		wait_b(1'b1);
		read_burst(4'h0, 16'h1380, 8'd3, 3'd2, burst_incr, 1'b1);
		report_test("backpressure_posted_write");

		repeat (4) @(negedge clk);
		$display("%0d tests run, %0d failed checks", test_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: src.f
source/axi_pkg.sv
source/sram_pkg.sv
source/aw_buffer.sv
source/burst_addr_gen.sv
source/sram_cell.sv
source/sram_axi_ctrl.sv
source/sram_axi_subsystem.sv
verification/tb_sram_axi_subsystem.sv

// File: Makefile
# Verilator build and run of the SRAM AXI testbench

BIN := obj_dir/Vtb_sram_axi_subsystem
SOURCES := $(filter-out +%,$(shell cat src.f))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) src.f
	verilator --binary --assert -Wno-fatal --top-module tb_sram_axi_subsystem -f src.f

# Fails unless the run prints the pass message
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
